// ==== include/l2_cfg.svh ====
`ifndef L2_CFG_SVH
`define L2_CFG_SVH

// byte address width.
`define L2_ADDR_W   32

// number of sets and the index width that selects one.
`define L2_SETS     8
`define L2_INDEX_W  3

// memory bus beat width and beats per cache line.
`define L2_BEAT_W   64
`define L2_BEATS    4

// byte offset within a line, log2 of (beat width / 8 * beats).
`define L2_OFFSET_W 5

// tag is what remains of the address above index and offset.
`define L2_TAG_W    24

`endif

// ==== project.f ====
+incdir+include
source/l2_pkg.sv
source/l2_cache_control.sv
source/l2_burst_counter.sv
source/l2_tag_array.sv
source/l2_data_array.sv
source/l2_cache.sv
tests/l2_pmem_model.sv
tests/l2_cache_tb.sv

// ==== source/l2_burst_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l2_cfg.svh"

module l2_burst_counter (
  input  logic              clk,
  input  logic              rst,
  input  logic              active,
  input  logic              pmem_resp,
  output l2_pkg::beat_cnt_t beat,
  output logic              burst_done
);

  import l2_pkg::*;

  logic last_beat;

  assign last_beat = (beat == beat_cnt_t'(`L2_BEATS - 1));

  // high together with the response to the final beat of a line.
  assign burst_done = active && pmem_resp && last_beat;

  always_ff @(posedge clk)
  begin
    if (rst)
      beat <= '0;
    else if (!active)
      beat <= '0; // every transfer starts at beat zero.
    else if (pmem_resp)
    begin
      if (last_beat)
        beat <= '0; // a writeback can run straight into a refill.
      else
        beat <= beat + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== source/l2_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l2_cfg.svh"

module l2_cache (
  input  logic          clk,
  input  logic          rst,
  input  logic          mem_read,
  input  logic          mem_write,
  input  l2_pkg::addr_t mem_address,
  input  l2_pkg::line_t mem_wdata,
  input  l2_pkg::beat_t pmem_rdata,
  input  logic          pmem_resp,
  output logic          mem_resp,
  output l2_pkg::line_t mem_rdata,
  output logic          pmem_read,
  output logic          pmem_write,
  output l2_pkg::addr_t pmem_address,
  output l2_pkg::beat_t pmem_wdata
);

  import l2_pkg::*;

  tag_t       req_tag;
  tag_t       victim_tag;
  index_t     index;
  beat_cnt_t  beat;
  logic       hit;
  logic       way_hit;
  logic       lru;
  logic       dirty_victim;
  logic       burst_done;
  logic [1:0] ld_tag;
  logic [1:0] ld_valid;
  logic [1:0] ld_dirty;
  logic       dirty_in;
  logic       ld_lru;
  logic       lru_in;
  logic       ld_data;
  logic       fill_active;
  logic       addr_victim_sel;
  logic       burst_active;

  assign req_tag = mem_address[`L2_ADDR_W-1 -: `L2_TAG_W];
  assign index   = mem_address[`L2_OFFSET_W +: `L2_INDEX_W];

  // memory always sees line-aligned addresses.
  assign pmem_address = {(addr_victim_sel ? victim_tag : req_tag), index,
                         {(`L2_OFFSET_W){1'b0}}};

  assign burst_active = pmem_read || pmem_write;

  l2_cache_control control_inst (
    .clk(clk), .rst(rst), .mem_read(mem_read), .mem_write(mem_write),
    .hit(hit), .way_hit(way_hit), .lru(lru), .dirty_victim(dirty_victim),
    .burst_done(burst_done), .mem_resp(mem_resp), .pmem_read(pmem_read),
    .pmem_write(pmem_write), .ld_tag(ld_tag), .ld_valid(ld_valid),
    .ld_dirty(ld_dirty), .dirty_in(dirty_in), .ld_lru(ld_lru), .lru_in(lru_in),
    .ld_data(ld_data), .fill_active(fill_active), .addr_victim_sel(addr_victim_sel)
  );

  l2_burst_counter burst_counter_inst (
    .clk(clk), .rst(rst), .active(burst_active), .pmem_resp(pmem_resp),
    .beat(beat), .burst_done(burst_done)
  );

  l2_tag_array tag_array_inst (
    .clk(clk), .rst(rst), .index(index), .tag(req_tag), .ld_tag(ld_tag),
    .ld_valid(ld_valid), .ld_dirty(ld_dirty), .dirty_in(dirty_in),
    .ld_lru(ld_lru), .lru_in(lru_in), .hit(hit), .way_hit(way_hit), .lru(lru),
    .dirty_victim(dirty_victim), .victim_tag(victim_tag)
  );

  l2_data_array data_array_inst (
    .clk(clk), .index(index), .way_hit(way_hit), .lru(lru), .ld_data(ld_data),
    .fill_active(fill_active), .pmem_resp(pmem_resp), .beat(beat),
    .wdata(mem_wdata), .pmem_rdata(pmem_rdata), .rdata(mem_rdata),
    .pmem_wdata(pmem_wdata)
  );

endmodule

`default_nettype wire

// ==== source/l2_cache_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_cache_control (
  input  logic       clk,
  input  logic       rst,
  input  logic       mem_read,
  input  logic       mem_write,
  input  logic       hit,
  input  logic       way_hit,
  input  logic       lru,
  input  logic       dirty_victim,
  input  logic       burst_done,
  output logic       mem_resp,
  output logic       pmem_read,
  output logic       pmem_write,
  output logic [1:0] ld_tag,
  output logic [1:0] ld_valid,
  output logic [1:0] ld_dirty,
  output logic       dirty_in,
  output logic       ld_lru,
  output logic       lru_in,
  output logic       ld_data,
  output logic       fill_active,
  output logic       addr_victim_sel
);

  import l2_pkg::*;

  ctrl_state_t state, next_state;

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= idle;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state = state;
    case (state)
      idle:
      begin
        if (mem_read || mem_write)
          next_state = check;
      end
      check:
      begin
        if (hit)
          next_state = idle; // the requester drops its request next cycle.
        else
          next_state = buffer;
      end
      buffer:
      begin
        // a dirty victim has to go out before the new line comes in.
        if (dirty_victim)
          next_state = write_to_mem;
        else
          next_state = read_from_mem;
      end
      write_to_mem:
      begin
        if (burst_done)
          next_state = read_from_mem;
      end
      read_from_mem:
      begin
        if (burst_done)
          next_state = check; // retry, which now hits.
      end
      default:
      begin
        next_state = idle;
      end
    endcase
  end

  always_comb
  begin
    mem_resp        = 1'b0;
    pmem_read       = 1'b0;
    pmem_write      = 1'b0;
    ld_tag          = 2'b00;
    ld_valid        = 2'b00;
    ld_dirty        = 2'b00;
    dirty_in        = 1'b0;
    ld_lru          = 1'b0;
    lru_in          = 1'b0;
    ld_data         = 1'b0;
    fill_active     = 1'b0;
    addr_victim_sel = 1'b0;

    case (state)
      check:
      begin
        if (hit)
        begin
          mem_resp = 1'b1;
          ld_lru   = 1'b1;
          lru_in   = ~way_hit; // the other way becomes least recently used.
          if (mem_write)
          begin
            ld_dirty[way_hit] = 1'b1;
            dirty_in          = 1'b1;
            ld_data           = 1'b1;
          end
        end
      end
      write_to_mem:
      begin
        pmem_write      = 1'b1;
        addr_victim_sel = 1'b1; // address comes from the victim tag.
        if (burst_done)
        begin
          ld_dirty[lru] = 1'b1;
          dirty_in      = 1'b0;
        end
      end
      read_from_mem:
      begin
        pmem_read   = 1'b1;
        fill_active = 1'b1;
        if (burst_done)
        begin
          // install the new line clean in the way that was replaced.
          ld_tag[lru]   = 1'b1;
          ld_valid[lru] = 1'b1;
          ld_dirty[lru] = 1'b1;
          dirty_in      = 1'b0;
        end
      end
      default:
      begin
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== source/l2_data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l2_cfg.svh"

module l2_data_array (
  input  logic              clk,
  input  l2_pkg::index_t    index,
  input  logic              way_hit,
  input  logic              lru,
  input  logic              ld_data,
  input  logic              fill_active,
  input  logic              pmem_resp,
  input  l2_pkg::beat_cnt_t beat,
  input  l2_pkg::line_t     wdata,
  input  l2_pkg::beat_t     pmem_rdata,
  output l2_pkg::line_t     rdata,
  output l2_pkg::beat_t     pmem_wdata
);

  import l2_pkg::*;

  line_t lines [2][`L2_SETS];

  always_ff @(posedge clk)
  begin
    if (ld_data)
      lines[way_hit][index] <= wdata;
    else if (fill_active && pmem_resp)
    begin
      // refill beats arrive in ascending order into the replaced way.
      lines[lru][index][beat*`L2_BEAT_W +: `L2_BEAT_W] <= pmem_rdata;
    end
  end

  assign rdata = lines[way_hit][index];

  // writeback streams the victim line one beat at a time.
  assign pmem_wdata = lines[lru][index][beat*`L2_BEAT_W +: `L2_BEAT_W];

endmodule

`default_nettype wire

// ==== source/l2_pkg.sv ====
`default_nettype none

`include "l2_cfg.svh"

package l2_pkg;

  typedef logic [`L2_ADDR_W-1:0]   addr_t;
  typedef logic [`L2_TAG_W-1:0]    tag_t;
  typedef logic [`L2_INDEX_W-1:0]  index_t;

  // a full line is the concatenation of all beats, beat zero at the bottom.
  typedef logic [`L2_BEAT_W*`L2_BEATS-1:0] line_t;
  typedef logic [`L2_BEAT_W-1:0]           beat_t;

  typedef logic [$clog2(`L2_BEATS)-1:0] beat_cnt_t;

  typedef enum logic [2:0] {
    idle,
    check,
    buffer,
    write_to_mem,
    read_from_mem
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== source/l2_tag_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l2_cfg.svh"

module l2_tag_array (
  input  logic           clk,
  input  logic           rst,
  input  l2_pkg::index_t index,
  input  l2_pkg::tag_t   tag,
  input  logic [1:0]     ld_tag,
  input  logic [1:0]     ld_valid,
  input  logic [1:0]     ld_dirty,
  input  logic           dirty_in,
  input  logic           ld_lru,
  input  logic           lru_in,
  output logic           hit,
  output logic           way_hit,
  output logic           lru,
  output logic           dirty_victim,
  output l2_pkg::tag_t   victim_tag
);

  import l2_pkg::*;

  tag_t       tags  [2][`L2_SETS];
  logic [1:0] valid [`L2_SETS];
  logic [1:0] dirty [`L2_SETS];
  logic       lru_bits [`L2_SETS];

  logic [1:0] way_match;

  // both ways are compared in parallel.
  assign way_match[0] = valid[index][0] && (tags[0][index] == tag);
  assign way_match[1] = valid[index][1] && (tags[1][index] == tag);

  assign hit     = |way_match;
  assign way_hit = way_match[1];

  // lru names the way that is replaced on the next miss.
  assign lru          = lru_bits[index];
  assign dirty_victim = valid[index][lru] && dirty[index][lru];
  assign victim_tag   = tags[lru][index];

  always_ff @(posedge clk)
  begin
    for (int w = 0; w < 2; w++)
    begin
      if (ld_tag[w])
        tags[w][index] <= tag;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int s = 0; s < `L2_SETS; s++)
      begin
        valid[s]    <= 2'b00;
        dirty[s]    <= 2'b00;
        lru_bits[s] <= 1'b0;
      end
    end
    else
    begin
      for (int w = 0; w < 2; w++)
      begin
        if (ld_valid[w])
          valid[index][w] <= 1'b1; // a line only leaves by replacement.
        if (ld_dirty[w])
          dirty[index][w] <= dirty_in;
      end
      if (ld_lru)
        lru_bits[index] <= lru_in;
    end
  end

endmodule

`default_nettype wire

// ==== tests/l2_cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l2_cfg.svh"

module l2_cache_tb;

  import l2_pkg::*;

  localparam int RESP_TIMEOUT = 200;

  logic  clk;
  logic  rst;
  logic  mem_read;
  logic  mem_write;
  logic  mem_resp;
  logic  pmem_read;
  logic  pmem_write;
  logic  pmem_resp;
  addr_t mem_address;
  addr_t pmem_address;
  line_t mem_wdata;
  line_t mem_rdata;
  beat_t pmem_rdata;
  beat_t pmem_wdata;
  int    read_beats;
  int    write_beats;
  addr_t last_rd_addr;
  addr_t last_wb_addr;
  line_t last_wb_line;

  // operation table, one entry per request.
  logic  op_write [$];
  addr_t op_addr  [$];
  line_t op_wdata [$];
  logic  op_wb    [$];

  logic  ref_valid [2][`L2_SETS];
  logic  ref_dirty [2][`L2_SETS];
  tag_t  ref_tag   [2][`L2_SETS];
  line_t ref_line  [2][`L2_SETS];
  logic  ref_lru   [`L2_SETS];
  line_t ref_mem   [addr_t]; // lines that the reference has written back.

  int error_count;
  int timeout_count;

  l2_cache l2_cache_inst (
    .clk(clk), .rst(rst), .mem_read(mem_read), .mem_write(mem_write),
    .mem_address(mem_address), .mem_wdata(mem_wdata), .pmem_rdata(pmem_rdata),
    .pmem_resp(pmem_resp), .mem_resp(mem_resp), .mem_rdata(mem_rdata),
    .pmem_read(pmem_read), .pmem_write(pmem_write), .pmem_address(pmem_address),
    .pmem_wdata(pmem_wdata)
  );

  l2_pmem_model pmem_model_inst (
    .clk(clk), .rst(rst), .pmem_read(pmem_read), .pmem_write(pmem_write),
    .pmem_address(pmem_address), .pmem_wdata(pmem_wdata), .pmem_resp(pmem_resp),
    .pmem_rdata(pmem_rdata), .read_beats(read_beats), .write_beats(write_beats),
    .last_rd_addr(last_rd_addr), .last_wb_addr(last_wb_addr),
    .last_wb_line(last_wb_line)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic report_error(input string msg);
    error_count++;
    $display("ERROR at %0t ns: %s", $time, msg);
  endtask

  function automatic beat_t pattern_beat(input addr_t a);
    return {a * 32'h9e37_79b9, a ^ 32'h1f66_c3a5};
  endfunction

  function automatic line_t memory_line(input addr_t line_addr);
    line_t l;
    if (ref_mem.exists(line_addr))
      return ref_mem[line_addr];
    for (int b = 0; b < `L2_BEATS; b++)
      l[b*`L2_BEAT_W +: `L2_BEAT_W] = pattern_beat(line_addr + addr_t'(b * (`L2_BEAT_W / 8)));
    return l;
  endfunction

  task automatic add_op(input logic wr, input addr_t addr, input line_t wdata, input logic wb);
    op_write.push_back(wr);
    op_addr.push_back(addr);
    op_wdata.push_back(wdata);
    op_wb.push_back(wb);
  endtask

  task automatic build_table();
    line_t w1;
    line_t w2;
    line_t w3;
    w1 = {64'h1111_2222_3333_4444, 64'h5555_6666_7777_8888,
          64'h9999_aaaa_bbbb_cccc, 64'hdddd_eeee_ffff_0001};
    w2 = {64'ha5a5_0000_0000_0004, 64'ha5a5_0000_0000_0003,
          64'ha5a5_0000_0000_0002, 64'ha5a5_0000_0000_0001};
    w3 = {64'h0f0f_1234_5678_9abc, 64'hf0f0_0000_ffff_0000,
          64'h0123_4567_89ab_cdef, 64'hfedc_ba98_7654_3210};
    add_op(1'b0, 32'h0000_1020, '0, 1'b0); // A misses in set 1.
    add_op(1'b0, 32'h0000_1028, '0, 1'b0);
    add_op(1'b0, 32'h0000_4040, '0, 1'b0); // D misses in set 2.
    add_op(1'b1, 32'h0000_4040, w1, 1'b0);
    add_op(1'b0, 32'h0000_4040, '0, 1'b0);
    add_op(1'b0, 32'h0000_2020, '0, 1'b0); // B fills the second way.
    add_op(1'b0, 32'h0000_1020, '0, 1'b0);
    add_op(1'b0, 32'h0000_3020, '0, 1'b0); // C has to replace B.
    add_op(1'b0, 32'h0000_1020, '0, 1'b0);
    add_op(1'b1, 32'h0000_1020, w2, 1'b0);
    add_op(1'b0, 32'h0000_2020, '0, 1'b0);
    add_op(1'b0, 32'h0000_3020, '0, 1'b1); // dirty A goes out.
    add_op(1'b0, 32'h0000_1020, '0, 1'b0);
    add_op(1'b1, 32'h0000_5040, w3, 1'b0);
    add_op(1'b0, 32'h0000_6040, '0, 1'b1);
    add_op(1'b0, 32'h0000_4040, '0, 1'b1);
  endtask

  task automatic clear_model();
    for (int s = 0; s < `L2_SETS; s++)
    begin
      ref_lru[s] = 1'b0;
      for (int w = 0; w < 2; w++)
      begin
        ref_valid[w][s] = 1'b0;
        ref_dirty[w][s] = 1'b0;
        ref_tag[w][s]   = '0;
        ref_line[w][s]  = '0;
      end
    end
  endtask

  // two-way LRU cache that fills on every miss and writes back dirty victims.
  task automatic predict(input logic wr, input addr_t addr, input line_t wdata,
                         output logic hit, output line_t rdata, output logic wb,
                         output addr_t wb_addr, output line_t wb_line);
    tag_t   t;
    index_t s;
    logic   w;
    t       = addr[`L2_ADDR_W-1 -: `L2_TAG_W];
    s       = addr[`L2_OFFSET_W +: `L2_INDEX_W];
    wb      = 1'b0;
    wb_addr = '0;
    wb_line = '0;
    hit = (ref_valid[0][s] && ref_tag[0][s] == t) || (ref_valid[1][s] && ref_tag[1][s] == t);
    w   = ref_valid[1][s] && ref_tag[1][s] == t;
    if (!hit)
    begin
      w = ref_lru[s];
      if (ref_valid[w][s] && ref_dirty[w][s])
      begin
        wb      = 1'b1;
        wb_addr = {ref_tag[w][s], s, {(`L2_OFFSET_W){1'b0}}};
        wb_line = ref_line[w][s];
        ref_mem[wb_addr] = wb_line;
      end
      ref_line[w][s]  = memory_line({t, s, {(`L2_OFFSET_W){1'b0}}});
      ref_tag[w][s]   = t;
      ref_valid[w][s] = 1'b1;
      ref_dirty[w][s] = 1'b0;
    end
    ref_lru[s] = ~w;
    if (wr)
    begin
      ref_line[w][s]  = wdata;
      ref_dirty[w][s] = 1'b1;
    end
    rdata = ref_line[w][s];
  endtask

  task automatic run_op(input int n);
    logic  exp_hit;
    logic  exp_wb;
    logic  got;
    line_t exp_rdata;
    line_t exp_wb_line;
    line_t rdata;
    addr_t exp_wb_addr;
    addr_t addr;
    addr_t base;
    int    cycles;
    int    rd0;
    int    wr0;
    int    rd1;
    int    wr1;
    addr = op_addr[n];
    base = {addr[`L2_ADDR_W-1:`L2_OFFSET_W], {(`L2_OFFSET_W){1'b0}}};
    predict(op_write[n], addr, op_wdata[n], exp_hit, exp_rdata, exp_wb, exp_wb_addr,
            exp_wb_line);
    @(negedge clk);
    rd0 = read_beats;
    wr0 = write_beats;
    @(posedge clk);
    mem_read    <= ~op_write[n];
    mem_write   <= op_write[n];
    mem_address <= addr;
    mem_wdata   <= op_wdata[n];
    cycles = 0;
    got    = 1'b0;
    while (!got && cycles < RESP_TIMEOUT)
    begin
      @(negedge clk);
      cycles++;
      got = mem_resp;
    end
    rdata = mem_rdata;
    rd1   = read_beats;
    wr1   = write_beats;
    @(posedge clk);
    mem_read  <= 1'b0;
    mem_write <= 1'b0;
    if (!got)
    begin
      timeout_count++;
      $display("operation %0d: mem_resp never came within %0d cycles", n, RESP_TIMEOUT);
      return;
    end
    if (!op_write[n])
    begin
      assert (rdata === exp_rdata)
        else report_error($sformatf("op %0d read data %h, expected %h", n, rdata, exp_rdata));
    end
    if (exp_hit)
    begin
      assert (cycles == 2)
        else report_error($sformatf("op %0d hit answered after %0d cycles", n, cycles));
    end
    else
    begin
      assert (last_rd_addr == base)
        else report_error($sformatf("op %0d refill started at %h", n, last_rd_addr));
    end
    assert (rd1 - rd0 == (exp_hit ? 0 : `L2_BEATS))
      else report_error($sformatf("op %0d saw %0d read beats", n, rd1 - rd0));
    assert (wr1 - wr0 == (op_wb[n] ? `L2_BEATS : 0))
      else report_error($sformatf("op %0d saw %0d write beats", n, wr1 - wr0));
    if (exp_wb)
    begin
      assert (last_wb_addr == exp_wb_addr && last_wb_line === exp_wb_line)
        else report_error($sformatf("op %0d wrote back %h to %h", n, last_wb_line,
                                    last_wb_addr));
    end
  endtask

  initial
  begin
    error_count   = 0;
    timeout_count = 0;
    rst         = 1'b1;
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    mem_address = '0;
    mem_wdata   = '0;
    clear_model();
    build_table();
    for (int i = 0; i < 10; i++)
    begin
      @(posedge clk);
      if (i == 7)
        rst <= 1'b0; // eight rising edges in reset.
      @(negedge clk);
      assert (!mem_resp && !pmem_read && !pmem_write)
        else report_error("response or memory request active around reset");
    end
    for (int n = 0; n < op_write.size(); n++)
    begin
      run_op(n);
      if (timeout_count != 0)
        break;
    end
    $display("checks done: %0d errors, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/l2_pmem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l2_cfg.svh"

module l2_pmem_model (
  input  logic          clk,
  input  logic          rst,
  input  logic          pmem_read,
  input  logic          pmem_write,
  input  l2_pkg::addr_t pmem_address,
  input  l2_pkg::beat_t pmem_wdata,
  output logic          pmem_resp,
  output l2_pkg::beat_t pmem_rdata,
  output int            read_beats,
  output int            write_beats,
  output l2_pkg::addr_t last_rd_addr,
  output l2_pkg::addr_t last_wb_addr,
  output l2_pkg::line_t last_wb_line
);

  import l2_pkg::*;

  beat_t mem [addr_t]; // only beats that were written back are stored.

  function automatic beat_t pattern_beat(input addr_t a);
    return {a * 32'h9e37_79b9, a ^ 32'h1f66_c3a5};
  endfunction

  initial
  begin
    int          delay;
    int          beat_idx;
    int unsigned seed_state;
    logic        s_rst;
    logic        s_rd;
    logic        s_wr;
    logic        s_resp;
    addr_t       s_addr;
    addr_t       a;
    beat_t       s_wdata;

    pmem_resp    = 1'b0;
    pmem_rdata   = '0;
    read_beats   = 0;
    write_beats  = 0;
    last_rd_addr = '0;
    last_wb_addr = '0;
    last_wb_line = '0;
    seed_state   = $urandom(32'h1f66); // seeds the generator of this process.
    delay        = -1;
    beat_idx     = 0;
    forever
    begin
      @(negedge clk); // requests are taken where they are stable.
      s_rst   = rst;
      s_rd    = pmem_read;
      s_wr    = pmem_write;
      s_resp  = pmem_resp;
      s_addr  = pmem_address;
      s_wdata = pmem_wdata;
      @(posedge clk);
      pmem_resp <= 1'b0;
      if (s_rst || !(s_rd || s_wr))
      begin
        delay    = -1;
        beat_idx = 0;
      end
      else if (!s_resp)
      begin
        if (delay < 0)
          delay = $urandom_range(3, 0);
        else
          delay--;
        if (delay == 0)
        begin
          a = s_addr + addr_t'(beat_idx * (`L2_BEAT_W / 8));
          if (s_wr)
          begin
            mem[a] = s_wdata;
            last_wb_addr <= s_addr;
            last_wb_line[beat_idx*`L2_BEAT_W +: `L2_BEAT_W] <= s_wdata;
            write_beats <= write_beats + 1;
          end
          else
          begin
            pmem_rdata <= mem.exists(a) ? mem[a] : pattern_beat(a);
            if (beat_idx == 0)
              last_rd_addr <= a;
            read_beats <= read_beats + 1;
          end
          pmem_resp <= 1'b1;
          delay     = -1;
          beat_idx  = (beat_idx + 1) % `L2_BEATS; // a refill may follow at once.
        end
      end
    end
  end

endmodule

`default_nettype wire
